// ==== hdl/rename_pkg.sv ====
package rename_pkg;

	// group and register file sizes
	localparam int NUM_SLOTS = 4;
	localparam int NUM_AREGS = 32;
	localparam int NUM_PREGS = 64;

	localparam int WIDTH_AREG = 5;
	localparam int WIDTH_PREG = 6;

	// free count must reach NUM_PREGS
	localparam int WIDTH_CNT = 7;

	// slot index and pop count (0 to NUM_SLOTS)
	localparam int WIDTH_SLOT = $clog2(NUM_SLOTS);
	localparam int WIDTH_POP = WIDTH_SLOT + 1;

	// architectural register index
	typedef logic [WIDTH_AREG-1:0] areg_t;

	// physical register index
	typedef logic [WIDTH_PREG-1:0] preg_t;

	// number of entries in the free list
	typedef logic [WIDTH_CNT-1:0] fcnt_t;

	// one bit per slot of a rename group
	typedef logic [NUM_SLOTS-1:0] slot_mask_t;

	// registers popped from the free list in one cycle
	typedef logic [WIDTH_POP-1:0] pop_t;

endpackage

// ==== hdl/rename_ifs.sv ====
`timescale 1ns/1ps

interface map_if;
	import rename_pkg::*;

	// read addresses per slot
	areg_t [NUM_SLOTS-1:0] rs1_addr;
	areg_t [NUM_SLOTS-1:0] rs2_addr;
	areg_t [NUM_SLOTS-1:0] rd_addr;

	// mapped physical registers
	preg_t [NUM_SLOTS-1:0] prs1;
	preg_t [NUM_SLOTS-1:0] prs2;
	preg_t [NUM_SLOTS-1:0] old_prd;

	// new mappings, address is rd_addr
	slot_mask_t wr_mask;
	preg_t [NUM_SLOTS-1:0] wr_preg;

	modport tbl (input rs1_addr, rs2_addr, rd_addr, wr_mask, wr_preg,
		output prs1, prs2, old_prd);
	modport user (output rs1_addr, rs2_addr, rd_addr, wr_mask, wr_preg,
		input prs1, prs2, old_prd);
endinterface

interface alloc_if;
	import rename_pkg::*;

	fcnt_t count;

	// next entries in queue order
	preg_t [NUM_SLOTS-1:0] head;

	// zero unless the group is accepted
	pop_t pop_cnt;

	modport queue (output count, head, input pop_cnt);
	modport user (input count, head, output pop_cnt);
endinterface

// ==== hdl/map_table.sv ====
`timescale 1ns/1ps

module map_table (
	input logic i_clk,
	input logic i_rst_n,
	map_if.tbl m
);
	import rename_pkg::*;

	preg_t map_q [NUM_AREGS];

	// combinational reads, three per slot
	always_comb begin
		for (int s = 0; s < NUM_SLOTS; s++) begin
			m.prs1[s] = map_q[m.rs1_addr[s]];
			m.prs2[s] = map_q[m.rs2_addr[s]];
			m.old_prd[s] = map_q[m.rd_addr[s]];
		end
	end

	// writes in slot order, the highest slot lands last
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int r = 0; r < NUM_AREGS; r++) begin
				map_q[r] <= preg_t'(r);
			end
		end else begin
			for (int s = 0; s < NUM_SLOTS; s++) begin
				if (m.wr_mask[s]) begin
					map_q[m.rd_addr[s]] <= m.wr_preg[s];
				end
			end
		end
	end

endmodule

// ==== hdl/free_list.sv ====
`timescale 1ns/1ps

module free_list (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_commit_valid,
	input rename_pkg::preg_t i_commit_preg,
	alloc_if.queue q
);
	import rename_pkg::*;

	preg_t fifo_q [NUM_PREGS];
	preg_t head_q;
	preg_t tail_q;
	fcnt_t count_q;

	// head window, pointer wraps at 64
	always_comb begin
		for (int k = 0; k < NUM_SLOTS; k++) begin
			q.head[k] = fifo_q[head_q + preg_t'(k)];
		end
	end

	assign q.count = count_q;

	// registers above the architectural ones start out free
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < NUM_PREGS - NUM_AREGS; i++) begin
				fifo_q[i] <= preg_t'(NUM_AREGS + i);
			end
		end else if (i_commit_valid) begin
			fifo_q[tail_q] <= i_commit_preg;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			head_q <= '0;
			tail_q <= preg_t'(NUM_PREGS - NUM_AREGS);
			count_q <= fcnt_t'(NUM_PREGS - NUM_AREGS);
		end else begin
			head_q <= head_q + preg_t'(q.pop_cnt);
			if (i_commit_valid) begin
				tail_q <= tail_q + 1'b1;
			end
			count_q <= count_q + fcnt_t'(i_commit_valid) - fcnt_t'(q.pop_cnt);
		end
	end

endmodule

// ==== hdl/busy_table.sv ====
`timescale 1ns/1ps

module busy_table (
	input logic i_clk,
	input logic i_rst_n,
	input rename_pkg::slot_mask_t i_set_mask,
	input rename_pkg::preg_t [rename_pkg::NUM_SLOTS-1:0] i_set_preg,
	input logic i_wb_valid,
	input rename_pkg::preg_t i_wb_preg,
	input rename_pkg::preg_t [rename_pkg::NUM_SLOTS-1:0] i_src1,
	input rename_pkg::preg_t [rename_pkg::NUM_SLOTS-1:0] i_src2,
	output rename_pkg::slot_mask_t o_rdy1,
	output rename_pkg::slot_mask_t o_rdy2
);
	import rename_pkg::*;

	logic [NUM_PREGS-1:0] busy_q;

	// a writeback in this cycle counts as ready
	function automatic logic src_ready(preg_t p);
		return !busy_q[p] || (i_wb_valid && (i_wb_preg == p));
	endfunction

	always_comb begin
		for (int s = 0; s < NUM_SLOTS; s++) begin
			o_rdy1[s] = src_ready(i_src1[s]);
			o_rdy2[s] = src_ready(i_src2[s]);
		end
	end

	// set after clear so a new allocation keeps its bit
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			busy_q <= '0;
		end else begin
			if (i_wb_valid) begin
				busy_q[i_wb_preg] <= 1'b0;
			end
			for (int s = 0; s < NUM_SLOTS; s++) begin
				if (i_set_mask[s]) begin
					busy_q[i_set_preg[s]] <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== hdl/rename_group.sv ====
`timescale 1ns/1ps

module rename_group (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_valid,
	input rename_pkg::slot_mask_t i_slot_valid,
	input rename_pkg::areg_t [rename_pkg::NUM_SLOTS-1:0] i_rd,
	input rename_pkg::areg_t [rename_pkg::NUM_SLOTS-1:0] i_rs1,
	input rename_pkg::areg_t [rename_pkg::NUM_SLOTS-1:0] i_rs2,
	map_if.user m,
	alloc_if.user a,
	output rename_pkg::slot_mask_t o_set_mask,
	output rename_pkg::preg_t [rename_pkg::NUM_SLOTS-1:0] o_set_preg,
	output rename_pkg::preg_t [rename_pkg::NUM_SLOTS-1:0] o_src1,
	output rename_pkg::preg_t [rename_pkg::NUM_SLOTS-1:0] o_src2,
	input rename_pkg::slot_mask_t i_rdy1,
	input rename_pkg::slot_mask_t i_rdy2,
	output logic o_ready,
	output logic o_out_valid,
	output rename_pkg::slot_mask_t o_out_mask,
	output rename_pkg::preg_t [rename_pkg::NUM_SLOTS-1:0] o_prd,
	output rename_pkg::preg_t [rename_pkg::NUM_SLOTS-1:0] o_prs1,
	output rename_pkg::preg_t [rename_pkg::NUM_SLOTS-1:0] o_prs2,
	output rename_pkg::preg_t [rename_pkg::NUM_SLOTS-1:0] o_old_prd,
	output rename_pkg::slot_mask_t o_rdy1_q,
	output rename_pkg::slot_mask_t o_rdy2_q
);
	import rename_pkg::*;

	slot_mask_t alloc_mask;
	slot_mask_t set_mask;
	slot_mask_t fwd1;
	slot_mask_t fwd2;
	pop_t rank;
	pop_t need;
	logic accept;
	preg_t [NUM_SLOTS-1:0] new_prd;
	preg_t [NUM_SLOTS-1:0] src1;
	preg_t [NUM_SLOTS-1:0] src2;
	preg_t [NUM_SLOTS-1:0] old_prd;

	// k-th allocating slot takes the k-th head entry
	always_comb begin
		rank = '0;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			alloc_mask[s] = i_slot_valid[s] && (i_rd[s] != '0);
			new_prd[s] = alloc_mask[s] ? a.head[rank[WIDTH_SLOT-1:0]] : '0;
			rank = rank + pop_t'(alloc_mask[s]);
		end
		need = rank;
	end

	assign o_ready = a.count >= fcnt_t'(need);
	assign accept = i_valid && o_ready;
	assign set_mask = accept ? alloc_mask : '0;

	assign a.pop_cnt = accept ? need : '0;
	assign m.rs1_addr = i_rs1;
	assign m.rs2_addr = i_rs2;
	assign m.rd_addr = i_rd;
	assign m.wr_mask = set_mask;
	assign m.wr_preg = new_prd;

	// later j overwrites, so the nearest earlier writer wins
	always_comb begin
		for (int s = 0; s < NUM_SLOTS; s++) begin
			src1[s] = m.prs1[s];
			src2[s] = m.prs2[s];
			old_prd[s] = m.old_prd[s];
			fwd1[s] = 1'b0;
			fwd2[s] = 1'b0;
			for (int j = 0; j < s; j++) begin
				if (alloc_mask[j] && (i_rd[j] == i_rs1[s])) begin
					src1[s] = new_prd[j];
					fwd1[s] = 1'b1;
				end
				if (alloc_mask[j] && (i_rd[j] == i_rs2[s])) begin
					src2[s] = new_prd[j];
					fwd2[s] = 1'b1;
				end
				if (alloc_mask[j] && (i_rd[j] == i_rd[s])) begin
					old_prd[s] = new_prd[j];
				end
			end
			if (!alloc_mask[s]) begin
				old_prd[s] = '0;
			end
		end
	end

	assign o_set_mask = set_mask;
	assign o_set_preg = new_prd;
	assign o_src1 = src1;
	assign o_src2 = src2;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_out_valid <= 1'b0;
			o_out_mask <= '0;
		end else begin
			o_out_valid <= accept;
			if (accept) begin
				o_out_mask <= i_slot_valid;
			end
		end
	end

	// renamed results
	always_ff @(posedge i_clk) begin
		if (accept) begin
			o_prd <= new_prd;
			o_prs1 <= src1;
			o_prs2 <= src2;
			o_old_prd <= old_prd;
			o_rdy1_q <= i_rdy1 & ~fwd1;
			o_rdy2_q <= i_rdy2 & ~fwd2;
		end
	end

endmodule

// ==== hdl/rename_unit.sv ====
`timescale 1ns/1ps

module rename_unit (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_valid,
	output logic o_ready,
	input rename_pkg::slot_mask_t i_slot_valid,
	input rename_pkg::areg_t [rename_pkg::NUM_SLOTS-1:0] i_rd,
	input rename_pkg::areg_t [rename_pkg::NUM_SLOTS-1:0] i_rs1,
	input rename_pkg::areg_t [rename_pkg::NUM_SLOTS-1:0] i_rs2,
	input logic i_commit_valid,
	input rename_pkg::preg_t i_commit_preg,
	input logic i_wb_valid,
	input rename_pkg::preg_t i_wb_preg,
	output logic o_out_valid,
	output rename_pkg::slot_mask_t o_out_mask,
	output rename_pkg::preg_t [rename_pkg::NUM_SLOTS-1:0] o_prd,
	output rename_pkg::preg_t [rename_pkg::NUM_SLOTS-1:0] o_prs1,
	output rename_pkg::preg_t [rename_pkg::NUM_SLOTS-1:0] o_prs2,
	output rename_pkg::preg_t [rename_pkg::NUM_SLOTS-1:0] o_old_prd,
	output rename_pkg::slot_mask_t o_rdy1,
	output rename_pkg::slot_mask_t o_rdy2,
	output rename_pkg::fcnt_t o_free_count
);
	import rename_pkg::*;

	slot_mask_t set_mask;
	preg_t [NUM_SLOTS-1:0] set_preg;
	preg_t [NUM_SLOTS-1:0] src1;
	preg_t [NUM_SLOTS-1:0] src2;
	slot_mask_t rdy1;
	slot_mask_t rdy2;

	map_if map_bus ();
	alloc_if alloc_bus ();

	assign o_free_count = alloc_bus.count;

	map_table u_map_table (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.m (map_bus.tbl)
	);

	free_list u_free_list (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.i_commit_valid (i_commit_valid),
		.i_commit_preg (i_commit_preg),
		.q (alloc_bus.queue)
	);

	busy_table u_busy_table (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.i_set_mask (set_mask),
		.i_set_preg (set_preg),
		.i_wb_valid (i_wb_valid),
		.i_wb_preg (i_wb_preg),
		.i_src1 (src1),
		.i_src2 (src2),
		.o_rdy1 (rdy1),
		.o_rdy2 (rdy2)
	);

	rename_group u_rename_group (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.i_valid (i_valid),
		.i_slot_valid (i_slot_valid),
		.i_rd (i_rd),
		.i_rs1 (i_rs1),
		.i_rs2 (i_rs2),
		.m (map_bus.user),
		.a (alloc_bus.user),
		.o_set_mask (set_mask),
		.o_set_preg (set_preg),
		.o_src1 (src1),
		.o_src2 (src2),
		.i_rdy1 (rdy1),
		.i_rdy2 (rdy2),
		.o_ready (o_ready),
		.o_out_valid (o_out_valid),
		.o_out_mask (o_out_mask),
		.o_prd (o_prd),
		.o_prs1 (o_prs1),
		.o_prs2 (o_prs2),
		.o_old_prd (o_old_prd),
		.o_rdy1_q (o_rdy1),
		.o_rdy2_q (o_rdy2)
	);

endmodule

// ==== testbench/tb_rename_unit.sv ====
`timescale 1ns/1ps

module tb_rename_unit;
	import rename_pkg::*;

	localparam int PERIOD = 10;
	localparam int ACCEPT_TRIES = 8;
	localparam string CASE_FILE = "testbench/rename_cases.txt";

	logic i_clk;
	logic i_rst_n;
	logic i_valid, i_commit_valid, i_wb_valid;
	logic o_ready, o_out_valid;
	slot_mask_t i_slot_valid, o_out_mask, o_rdy1, o_rdy2;
	areg_t [NUM_SLOTS-1:0] i_rd, i_rs1, i_rs2;
	preg_t i_commit_preg, i_wb_preg;
	preg_t [NUM_SLOTS-1:0] o_prd, o_prs1, o_prs2, o_old_prd;
	fcnt_t o_free_count;

	int fd;
	int limit_cycles;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;
	logic [8*32-1:0] test_name;
	// fields of a group line after the op code
	int fld [32];
	logic wb_pending;
	preg_t wb_pending_preg;

	rename_unit dut (.*);

	initial begin
		i_clk = 1'b0;
		forever #(PERIOD/2) i_clk = ~i_clk;
	end

	task automatic note_mismatch(input string what, input int got, input int exp);
		$display("CHECK FAILED at %0t: %0s is %0d, expected %0d", $time, what, got, exp);
		errors++;
		test_errors++;
	endtask

	task automatic note_failure(input string msg);
		$display("at %0t: %0s", $time, msg);
		errors++;
		test_errors++;
	endtask

	task automatic close_test();
		if (test_name != '0) begin
			tests_run++;
			if (test_errors == 0) begin
				$display("test %0s: pass", test_name);
			end else begin
				tests_failed++;
				$display("test %0s: fail with %0d errors", test_name, test_errors);
			end
		end
		test_name = '0;
		test_errors = 0;
	endtask

	function automatic int count_lines(input int f);
		int c;
		int lines;
		lines = 0;
		c = $fgetc(f);
		while (c != -1) begin
			if (c == 10) begin
				lines++;
			end
			c = $fgetc(f);
		end
		return lines;
	endfunction

	task automatic skip_line();
		int c;
		c = $fgetc(fd);
		while (c != 10 && c != -1) begin
			c = $fgetc(fd);
		end
	endtask

	task automatic check_outputs();
		if (o_out_mask !== slot_mask_t'(fld[1])) begin
			note_mismatch("slot mask", int'(o_out_mask), fld[1]);
		end
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (o_prd[s] !== preg_t'(fld[14 + s])) begin
				note_mismatch($sformatf("prd of slot %0d", s), int'(o_prd[s]), fld[14 + s]);
			end
			if (o_prs1[s] !== preg_t'(fld[18 + s])) begin
				note_mismatch($sformatf("prs1 of slot %0d", s), int'(o_prs1[s]), fld[18 + s]);
			end
			if (o_prs2[s] !== preg_t'(fld[22 + s])) begin
				note_mismatch($sformatf("prs2 of slot %0d", s), int'(o_prs2[s]), fld[22 + s]);
			end
			if (o_old_prd[s] !== preg_t'(fld[26 + s])) begin
				note_mismatch($sformatf("old prd of slot %0d", s), int'(o_old_prd[s]),
					fld[26 + s]);
			end
		end
		if (o_rdy1 !== slot_mask_t'(fld[30])) begin
			note_mismatch("rs1 ready mask", int'(o_rdy1), fld[30]);
		end
		if (o_rdy2 !== slot_mask_t'(fld[31])) begin
			note_mismatch("rs2 ready mask", int'(o_rdy2), fld[31]);
		end
	endtask

	task automatic run_group();
		int n;
		int v;
		int tries;
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < 32; i++) begin
			// masks are hex and registers decimal
			if (i == 1 || i >= 30) begin
				n = $fscanf(fd, "%h", v);
			end else begin
				n = $fscanf(fd, "%d", v);
			end
			ok = ok && (n == 1);
			fld[i] = v;
		end
		if (!ok) begin
			note_failure("a group line in the case file is cut short");
		end else begin
			@(negedge i_clk);
			i_valid = 1'b1;
			i_slot_valid = slot_mask_t'(fld[1]);
			for (int s = 0; s < NUM_SLOTS; s++) begin
				i_rd[s] = areg_t'(fld[2 + s]);
				i_rs1[s] = areg_t'(fld[6 + s]);
				i_rs2[s] = areg_t'(fld[10 + s]);
			end
			// a held writeback lands in the same cycle as the group
			i_wb_valid = wb_pending;
			i_wb_preg = wb_pending_preg;
			wb_pending = 1'b0;
			#1;
			tries = 0;
			while (fld[0] != 0 && o_ready !== 1'b1 && tries < ACCEPT_TRIES) begin
				@(negedge i_clk);
				#1;
				tries++;
			end
			if (fld[0] == 0 && o_ready !== 1'b0) begin
				note_failure("a group was accepted with too few free registers");
			end
			if (fld[0] != 0 && o_ready !== 1'b1) begin
				note_failure("a group was never accepted");
			end
			@(negedge i_clk);
			i_valid = 1'b0;
			i_wb_valid = 1'b0;
			if (o_out_valid !== (fld[0] != 0)) begin
				note_failure("output valid does not follow the acceptance of the group");
			end else if (fld[0] != 0) begin
				check_outputs();
			end
		end
	endtask

	task automatic run_cases();
		int n;
		int a;
		int b;
		logic [8*32-1:0] word;
		logic more;
		more = 1'b1;
		while (more) begin
			word = '0;
			n = $fscanf(fd, "%s", word);
			if (n != 1) begin
				more = 1'b0;
			end else if (word == "#") begin
				skip_line();
			end else if (word == "T") begin
				close_test();
				n = $fscanf(fd, "%s", test_name);
			end else if (word == "G") begin
				run_group();
			end else if (word == "C") begin
				n = $fscanf(fd, "%d", a);
				@(negedge i_clk);
				i_commit_valid = 1'b1;
				i_commit_preg = preg_t'(a);
				@(negedge i_clk);
				i_commit_valid = 1'b0;
			end else if (word == "W") begin
				n = $fscanf(fd, "%d %d", a, b);
				if (b != 0) begin
					wb_pending = 1'b1;
					wb_pending_preg = preg_t'(a);
				end else begin
					@(negedge i_clk);
					i_wb_valid = 1'b1;
					i_wb_preg = preg_t'(a);
					@(negedge i_clk);
					i_wb_valid = 1'b0;
				end
			end else if (word == "I") begin
				n = $fscanf(fd, "%d", a);
				repeat (a) @(negedge i_clk);
			end else if (word == "F") begin
				n = $fscanf(fd, "%d", a);
				@(negedge i_clk);
				if (o_free_count !== fcnt_t'(a)) begin
					note_mismatch("free count", int'(o_free_count), a);
				end
			end else begin
				note_failure($sformatf("unknown operation %0s in the case file", word));
				skip_line();
			end
		end
	endtask

	initial begin
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_name = '0;
		wb_pending = 1'b0;
		wb_pending_preg = '0;
		i_rst_n = 1'b0;
		i_valid = 1'b0;
		i_slot_valid = '0;
		i_rd = '0;
		i_rs1 = '0;
		i_rs2 = '0;
		i_commit_valid = 1'b0;
		i_commit_preg = '0;
		i_wb_valid = 1'b0;
		i_wb_preg = '0;
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			$display("could not open the case file %0s", CASE_FILE);
			$display("Errors found");
			$finish;
		end else begin
			limit_cycles = count_lines(fd) * 20 + 100;
			$fclose(fd);
			fd = $fopen(CASE_FILE, "r");
			repeat (2) @(posedge i_clk);
			@(negedge i_clk);
			i_rst_n = 1'b1;
			// output stage starts empty
			if (o_out_valid !== 1'b0) begin
				note_mismatch("output valid after reset", int'(o_out_valid), 0);
			end
			if (o_out_mask !== '0) begin
				note_mismatch("slot mask after reset", int'(o_out_mask), 0);
			end
			run_cases();
			$fclose(fd);
			close_test();
			$display("tests %0d, failed tests %0d, errors %0d", tests_run, tests_failed, errors);
			if (errors == 0) begin
				$display("No errors");
			end else begin
				$display("Errors found");
			end
			$finish;
		end
	end

	// watchdog allows 20 cycles per case line
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge i_clk);
		$display("the run timed out after %0d cycles", limit_cycles);
		$display("Errors found");
		$finish;
	end

endmodule

// ==== testbench/rename_cases.txt ====
# G accept mask rd0-3 rs1_0-3 rs2_0-3, then expected prd0-3 prs1_0-3 prs2_0-3 old0-3 rdy1 rdy2
# masks hex, bit 0 is slot 0; C preg; W preg with_next_group; I cycles; F free count; T name
T reset_alloc
F 32
G 1 f 01 02 03 04 05 06 07 08 09 10 11 12 32 33 34 35 05 06 07 08 09 10 11 12 01 02 03 04 f f
F 28
T intra_group
G 1 f 05 06 07 07 10 05 04 06 02 03 00 09 36 37 38 39 10 36 35 37 33 34 00 09 05 06 07 38 1 c
G 1 1 00 00 00 00 07 00 00 00 06 00 00 00 00 00 00 00 39 00 00 00 37 00 00 00 00 00 00 00 e e
F 24
T dest_zero
G 1 b 08 00 09 10 11 13 15 08 12 14 16 09 40 00 00 41 11 13 15 40 12 14 16 09 08 00 00 10 7 f
F 22
T busy_wb
G 1 1 00 00 00 00 01 00 00 00 02 00 00 00 00 00 00 00 32 00 00 00 33 00 00 00 00 00 00 00 e e
W 32 0
G 1 1 00 00 00 00 01 00 00 00 02 00 00 00 00 00 00 00 32 00 00 00 33 00 00 00 00 00 00 00 f e
W 33 1
G 1 1 00 00 00 00 01 00 00 00 02 00 00 00 00 00 00 00 32 00 00 00 33 00 00 00 00 00 00 00 f f
I 2
F 22
T stall_commit
G 1 f 11 12 13 14 00 00 00 00 00 00 00 00 42 43 44 45 00 00 00 00 00 00 00 00 11 12 13 14 f f
G 1 f 15 16 17 18 00 00 00 00 00 00 00 00 46 47 48 49 00 00 00 00 00 00 00 00 15 16 17 18 f f
G 1 f 19 20 21 22 00 00 00 00 00 00 00 00 50 51 52 53 00 00 00 00 00 00 00 00 19 20 21 22 f f
G 1 f 23 24 25 26 00 00 00 00 00 00 00 00 54 55 56 57 00 00 00 00 00 00 00 00 23 24 25 26 f f
G 1 f 27 28 29 30 00 00 00 00 00 00 00 00 58 59 60 61 00 00 00 00 00 00 00 00 27 28 29 30 f f
F 2
G 0 f 01 02 03 04 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 0
F 2
C 1
F 3
G 1 7 01 02 03 00 00 00 00 00 00 00 00 00 62 63 01 00 00 00 00 00 00 00 00 00 32 33 34 00 f f
F 0
G 0 1 05 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 0
C 5
F 1

// ==== Makefile ====
VERILATOR ?= verilator
BUILD_DIR ?= build
LOG ?= sim.log
TOP ?= tb_rename_unit
FILELIST ?= sources.f

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) --binary -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "simulation FAILED"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sources.f ====
hdl/rename_pkg.sv
hdl/rename_ifs.sv
hdl/map_table.sv
hdl/free_list.sv
hdl/busy_table.sv
hdl/rename_group.sv
hdl/rename_unit.sv
testbench/tb_rename_unit.sv
